/* hdl/xmodem_pkg.sv */
package xmodem_pkg;

    // protocol bytes
    localparam logic [7:0] SOH = 8'h01;
    localparam logic [7:0] EOT = 8'h04;
    localparam logic [7:0] ACK = 8'h06;
    localparam logic [7:0] NAK = 8'h15;

    // serial bit timing is small for simulation
    localparam int CYC_PER_BIT = 16;
    localparam int CYC_W = $clog2(CYC_PER_BIT);
    localparam logic [CYC_W-1:0] BIT_LAST = CYC_W'(CYC_PER_BIT - 1);
    localparam logic [CYC_W-1:0] BIT_HALF = CYC_W'(CYC_PER_BIT / 2);

    // block framing
    localparam int BLOCK_BYTES = 128;
    localparam int BYTE_CNT_W = $clog2(BLOCK_BYTES);
    localparam logic [BYTE_CNT_W-1:0] BYTE_LAST = BYTE_CNT_W'(BLOCK_BYTES - 1);

    // idle time before a NAK is repeated
    localparam int NAK_TIMEOUT_CYC = 50000;
    localparam int TIMER_W = $clog2(NAK_TIMEOUT_CYC);
    localparam logic [TIMER_W-1:0] TIMER_LAST = TIMER_W'(NAK_TIMEOUT_CYC - 1);

    // retry limits
    localparam int MAX_RETRY = 10;
    localparam int RETRY_W = $clog2(MAX_RETRY + 1);
    localparam logic [RETRY_W-1:0] RETRY_LIMIT = RETRY_W'(MAX_RETRY);

endpackage

/* hdl/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk,
    input  logic       rst,
    input  logic       rx_pin,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid
);

    typedef enum logic {
        RX_IDLE,
        RX_BUSY
    } rx_state_t;

    rx_state_t state;

    logic rx_meta;
    logic rx_s;
    logic [xmodem_pkg::CYC_W-1:0] cyc_cnt;
    logic [3:0] sample_cnt;
    logic tick;
    logic take_data;

    // line idles high
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_s <= 1'b1;
        end else begin
            rx_meta <= rx_pin;
            rx_s <= rx_meta;
        end
    end

    assign tick = (cyc_cnt == xmodem_pkg::BIT_LAST);

    // samples 1 to 8 are the data bits
    assign take_data = (state == RX_BUSY) && tick &&
                       (sample_cnt != 4'd0) && (sample_cnt != 4'd9);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RX_IDLE;
            cyc_cnt <= '0;
            sample_cnt <= '0;
            rx_byte_valid <= 1'b0;
        end else begin
            rx_byte_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (!rx_s) begin
                        // half period preload puts samples mid-bit
                        state <= RX_BUSY;
                        cyc_cnt <= xmodem_pkg::BIT_HALF;
                        sample_cnt <= '0;
                    end
                end
                RX_BUSY: begin
                    if (tick) begin
                        cyc_cnt <= '0;
                        sample_cnt <= sample_cnt + 4'd1;
                        if ((sample_cnt == 4'd0) && rx_s) begin
                            // a start bit that did not hold was a glitch
                            state <= RX_IDLE;
                        end else if (sample_cnt == 4'd9) begin
                            // strobe only with a good stop bit
                            rx_byte_valid <= rx_s;
                            state <= RX_IDLE;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= RX_IDLE;
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (take_data) begin
            rx_byte <= {rx_s, rx_byte[7:1]};
        end
    end

endmodule

/* hdl/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       tx,
    output logic       tx_busy
);

    logic [9:0] frame;
    logic [xmodem_pkg::CYC_W-1:0] cyc_cnt;
    logic [3:0] bit_cnt;
    logic tick;

    assign tick = (cyc_cnt == xmodem_pkg::BIT_LAST);

    // bit 0 of the frame is the line
    assign tx = frame[0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            frame <= '1;
            tx_busy <= 1'b0;
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                // stop, data, start
                frame <= {1'b1, tx_data, 1'b0};
                tx_busy <= 1'b1;
                cyc_cnt <= '0;
                bit_cnt <= '0;
            end
        end else if (tick) begin
            cyc_cnt <= '0;
            // ones fill in behind, so the line ends high
            frame <= {1'b1, frame[9:1]};
            if (bit_cnt == 4'd9) begin
                tx_busy <= 1'b0;
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

endmodule

/* hdl/xmodem_block_checker.sv */
`timescale 1ns/1ps

module xmodem_block_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] rx_byte,
    input  logic       rx_byte_valid,
    output logic       block_done,
    output logic       block_ok,
    output logic       eot_seen,
    output logic       msg_byte_valid,
    output logic [7:0] msg_byte,
    output logic       block_valid,
    output logic [7:0] block_num
);

    typedef enum logic [2:0] {
        B_SOH,
        B_NUM,
        B_CMP,
        B_DATA,
        B_SUM
    } blk_state_t;

    blk_state_t state;

    logic [7:0] num_rx;
    logic [7:0] last_good;
    logic [7:0] sum;
    logic [xmodem_pkg::BYTE_CNT_W-1:0] byte_cnt;
    logic num_err;
    logic cmp_ok;
    logic num_in_seq;
    logic soh_taken;

    assign soh_taken = rx_byte_valid && (state == B_SOH) && (rx_byte == xmodem_pkg::SOH);
    assign eot_seen = rx_byte_valid && (state == B_SOH) && (rx_byte == xmodem_pkg::EOT);

    assign msg_byte = rx_byte;
    assign msg_byte_valid = rx_byte_valid && (state == B_DATA);

    // verdict on the checksum byte itself
    assign block_done = rx_byte_valid && (state == B_SUM);
    assign block_ok = !num_err && (sum == rx_byte);
    assign block_valid = block_done && block_ok;
    assign block_num = last_good;

    // same number means the host resent after a lost ACK
    assign cmp_ok = (rx_byte == ~num_rx);
    assign num_in_seq = (num_rx == last_good) || (num_rx == last_good + 8'd1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= B_SOH;
            byte_cnt <= '0;
            num_err <= 1'b0;
            last_good <= 8'h00;
        end else if (rx_byte_valid) begin
            case (state)
                B_SOH: begin
                    byte_cnt <= '0;
                    if (soh_taken) begin
                        state <= B_NUM;
                    end
                end
                B_NUM: begin
                    state <= B_CMP;
                end
                B_CMP: begin
                    num_err <= !cmp_ok || !num_in_seq;
                    state <= B_DATA;
                end
                B_DATA: begin
                    byte_cnt <= byte_cnt + 1'b1;
                    if (byte_cnt == xmodem_pkg::BYTE_LAST) begin
                        state <= B_SUM;
                    end
                end
                B_SUM: begin
                    if (block_ok) begin
                        last_good <= num_rx;
                    end
                    state <= B_SOH;
                end
                default: begin
                    state <= B_SOH;
                end
            endcase
        end
    end

    // running checksum over the payload only
    always_ff @(posedge clk) begin
        if (soh_taken) begin
            sum <= 8'h00;
        end else if (msg_byte_valid) begin
            sum <= sum + rx_byte;
        end
        if (rx_byte_valid && (state == B_NUM)) begin
            num_rx <= rx_byte;
        end
    end

endmodule

/* hdl/xmodem_protocol_ctrl.sv */
`timescale 1ns/1ps

module xmodem_protocol_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_pulse,
    input  logic       block_done,
    input  logic       block_ok,
    input  logic       eot_seen,
    input  logic       tx_busy,
    output logic       tx_start,
    output logic [7:0] tx_data,
    output logic       done
);

    typedef enum logic {
        C_IDLE,
        C_ACTIVE
    } ctrl_state_t;

    ctrl_state_t state;

    logic [xmodem_pkg::TIMER_W-1:0] nak_timer;
    logic [xmodem_pkg::RETRY_W-1:0] timeout_cnt;
    logic [xmodem_pkg::RETRY_W-1:0] bad_cnt;
    logic timer_exp;
    logic give_up;
    logic tx_free;
    logic reply_req;
    logic [7:0] reply_byte;
    logic pend;
    logic [7:0] pend_byte;

    assign timer_exp = (state == C_ACTIVE) && (nak_timer == xmodem_pkg::TIMER_LAST);
    assign give_up = (timeout_cnt == xmodem_pkg::RETRY_LIMIT) ||
                     (bad_cnt == xmodem_pkg::RETRY_LIMIT);

    // the transmitter raises busy one cycle after start
    assign tx_free = !tx_busy && !tx_start;

    always_comb begin
        reply_req = 1'b0;
        reply_byte = xmodem_pkg::NAK;
        case (state)
            C_IDLE: begin
                reply_req = start_pulse;
            end
            C_ACTIVE: begin
                if (!give_up) begin
                    if (eot_seen) begin
                        reply_req = 1'b1;
                        reply_byte = xmodem_pkg::ACK;
                    end else if (block_done) begin
                        reply_req = 1'b1;
                        reply_byte = block_ok ? xmodem_pkg::ACK : xmodem_pkg::NAK;
                    end else if (timer_exp) begin
                        reply_req = 1'b1;
                    end
                end
            end
            default: begin
                reply_req = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= C_IDLE;
            nak_timer <= '0;
            timeout_cnt <= '0;
            bad_cnt <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (start_pulse) begin
                        state <= C_ACTIVE;
                        nak_timer <= '0;
                        timeout_cnt <= '0;
                        bad_cnt <= '0;
                    end
                end
                C_ACTIVE: begin
                    if (give_up) begin
                        state <= C_IDLE;
                    end else if (eot_seen) begin
                        done <= 1'b1;
                        state <= C_IDLE;
                    end else if (block_done) begin
                        nak_timer <= '0;
                        if (block_ok) begin
                            timeout_cnt <= '0;
                            bad_cnt <= '0;
                        end else begin
                            bad_cnt <= bad_cnt + 1'b1;
                        end
                    end else if (timer_exp) begin
                        nak_timer <= '0;
                        timeout_cnt <= timeout_cnt + 1'b1;
                    end else begin
                        nak_timer <= nak_timer + 1'b1;
                    end
                end
                default: begin
                    state <= C_IDLE;
                end
            endcase
        end
    end

    // at most one reply waits for the transmitter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tx_start <= 1'b0;
            pend <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            if (pend && tx_free) begin
                tx_start <= 1'b1;
                pend <= reply_req;
            end else if (reply_req) begin
                if (tx_free) begin
                    tx_start <= 1'b1;
                end else begin
                    pend <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pend && tx_free) begin
            tx_data <= pend_byte;
        end else if (reply_req && tx_free) begin
            tx_data <= reply_byte;
        end
        if (reply_req && (pend || !tx_free)) begin
            pend_byte <= reply_byte;
        end
    end

endmodule

/* hdl/xmodem_rx_top.sv */
`timescale 1ns/1ps

module xmodem_rx_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_btn,
    input  logic       rx_pin,
    output logic       tx,
    output logic       done,
    output logic       block_valid,
    output logic       msg_byte_valid,
    output logic [7:0] msg_byte,
    output logic [7:0] block_num
);

    logic [1:0] btn_sync;
    logic       start_pulse;
    logic [7:0] rx_byte;
    logic       rx_byte_valid;
    logic       block_done;
    logic       block_ok;
    logic       eot_seen;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    // a press of the active low button is a falling edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_sync <= 2'b11;
            start_pulse <= 1'b0;
        end else begin
            btn_sync <= {btn_sync[0], start_btn};
            start_pulse <= btn_sync[1] && !btn_sync[0];
        end
    end

    uart_rx uart_rx_inst (
        .clk           (clk),
        .rst           (rst),
        .rx_pin        (rx_pin),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid)
    );

    xmodem_block_checker xmodem_block_checker_inst (
        .clk            (clk),
        .rst            (rst),
        .rx_byte        (rx_byte),
        .rx_byte_valid  (rx_byte_valid),
        .block_done     (block_done),
        .block_ok       (block_ok),
        .eot_seen       (eot_seen),
        .msg_byte_valid (msg_byte_valid),
        .msg_byte       (msg_byte),
        .block_valid    (block_valid),
        .block_num      (block_num)
    );

    xmodem_protocol_ctrl xmodem_protocol_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .block_done  (block_done),
        .block_ok    (block_ok),
        .eot_seen    (eot_seen),
        .tx_busy     (tx_busy),
        .tx_start    (tx_start),
        .tx_data     (tx_data),
        .done        (done)
    );

    uart_tx uart_tx_inst (
        .clk      (clk),
        .rst      (rst),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

endmodule

/* tb/xmodem_checker.sv */
`timescale 1ns/1ps

module xmodem_checker (
    input  logic       clk,
    input  logic       rst,
    input  logic       tx,
    input  logic       done,
    input  logic       block_valid,
    input  logic       msg_byte_valid,
    input  logic [7:0] msg_byte,
    input  logic [7:0] block_num,
    output int         reply_cnt,
    output int         err_cnt
);

    localparam int CPB = xmodem_pkg::CYC_PER_BIT;

    logic [7:0] exp_reply[$];
    logic [7:0] exp_payload[$];
    logic [7:0] exp_num[$];
    int exp_done = 0;
    logic [7:0] last_num = 8'h00;
    logic [7:0] next_num = 8'h00;
    logic num_due = 1'b0;
    logic dec_busy = 1'b0;
    int phase = 0;
    logic [7:0] dec_byte = 8'h00;

    initial begin
        reply_cnt = 0;
        err_cnt = 0;
    end

    task automatic mismatch(input string msg);
        err_cnt++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic expect_reply(input logic [7:0] b);
        exp_reply.push_back(b);
    endtask

    task automatic expect_payload(input logic [7:0] b);
        exp_payload.push_back(b);
    endtask

    task automatic expect_block(input logic [7:0] num);
        exp_num.push_back(num);
    endtask

    task automatic expect_done();
        exp_done++;
    endtask

    task automatic check_drained();
        if (exp_reply.size() != 0) begin
            err_cnt++;
            $display("%0d expected replies never appeared on tx", exp_reply.size());
        end
        if (exp_payload.size() != 0) begin
            err_cnt++;
            $display("%0d expected payload bytes never appeared", exp_payload.size());
        end
        if (exp_num.size() != 0) begin
            err_cnt++;
            $display("%0d expected block_valid strobes never appeared", exp_num.size());
        end
        if (exp_done != 0) begin
            err_cnt++;
            $display("%0d expected done strobes never appeared", exp_done);
        end
    endtask

    task automatic take_reply(input logic [7:0] b);
        logic [7:0] want;
        reply_cnt++;
        if (exp_reply.size() == 0) begin
            mismatch($sformatf("unexpected reply %02h on tx", b));
        end else begin
            want = exp_reply.pop_front();
            if (b !== want) begin
                mismatch($sformatf("reply %02h on tx, expected %02h", b, want));
            end
        end
    endtask

    // tx decoder samples mid-bit on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            dec_busy = 1'b0;
        end else if (!dec_busy) begin
            if (!tx) begin
                dec_busy = 1'b1;
                phase = 0;
            end
        end else begin
            phase = phase + 1;
            if (phase % CPB == CPB / 2) begin
                if (phase < CPB) begin
                    if (tx) begin
                        err_cnt++;
                        $display("start bit on tx did not hold at %0t ns", $time);
                        dec_busy = 1'b0;
                    end
                end else if (phase < 9 * CPB) begin
                    dec_byte = {tx, dec_byte[7:1]};
                end else begin
                    dec_busy = 1'b0;
                    if (!tx) begin
                        err_cnt++;
                        $display("stop bit on tx was low at %0t ns", $time);
                    end else begin
                        take_reply(dec_byte);
                    end
                end
            end
        end
    end

    // block_num settles the cycle after block_valid
    always @(negedge clk) begin
        if (!rst) begin
            if (num_due) begin
                if (block_num !== next_num) begin
                    mismatch($sformatf("block_num %02h, expected %02h", block_num, next_num));
                end
                last_num = block_num;
                num_due = 1'b0;
            end else if (block_num !== last_num) begin
                mismatch($sformatf("block_num moved to %02h without block_valid", block_num));
                last_num = block_num;
            end
            if (msg_byte_valid) begin
                if (exp_payload.size() == 0) begin
                    mismatch($sformatf("unexpected payload byte %02h", msg_byte));
                end else if (msg_byte !== exp_payload[0]) begin
                    mismatch($sformatf("payload byte %02h, expected %02h",
                                       msg_byte, exp_payload[0]));
                    void'(exp_payload.pop_front());
                end else begin
                    void'(exp_payload.pop_front());
                end
            end
            if (block_valid) begin
                if (exp_num.size() == 0) begin
                    mismatch("unexpected block_valid");
                end else begin
                    next_num = exp_num.pop_front();
                    num_due = 1'b1;
                end
            end
            if (done) begin
                if (exp_done == 0) begin
                    mismatch("unexpected done strobe");
                end else begin
                    exp_done--;
                end
            end
        end
    end

endmodule

/* tb/tb_xmodem.sv */
`timescale 1ns/1ps

module tb_xmodem;

    localparam int CPB = xmodem_pkg::CYC_PER_BIT;
    localparam int REPLY_WAIT = 40 * CPB;
    localparam int TIMEOUT_WAIT = xmodem_pkg::NAK_TIMEOUT_CYC + REPLY_WAIT;
    localparam logic [31:0] LFSR_SEED = 32'h5a7f1db0;
    localparam string INPUT_FILE = "tb/xmodem_input.txt";

    logic clk = 1'b0;
    logic rst;
    logic start_btn;
    logic rx_pin;
    logic tx;
    logic done;
    logic block_valid;
    logic msg_byte_valid;
    logic [7:0] msg_byte;
    logic [7:0] block_num;
    int reply_cnt;
    int err_cnt;
    int host_err = 0;
    logic [31:0] lfsr = LFSR_SEED;

    always #4 clk = ~clk;

    xmodem_rx_top xmodem_rx_top_inst (
        .clk            (clk),
        .rst            (rst),
        .start_btn      (start_btn),
        .rx_pin         (rx_pin),
        .tx             (tx),
        .done           (done),
        .block_valid    (block_valid),
        .msg_byte_valid (msg_byte_valid),
        .msg_byte       (msg_byte),
        .block_num      (block_num)
    );

    xmodem_checker xmodem_checker_inst (
        .clk            (clk),
        .rst            (rst),
        .tx             (tx),
        .done           (done),
        .block_valid    (block_valid),
        .msg_byte_valid (msg_byte_valid),
        .msg_byte       (msg_byte),
        .block_num      (block_num),
        .reply_cnt      (reply_cnt),
        .err_cnt        (err_cnt)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // one step per payload bit
    task automatic next_payload_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0];
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx_pin = frame[i];
            repeat (CPB) @(negedge clk);
        end
    endtask

    task automatic wait_reply(input int limit, input string what);
        int seen;
        int n;
        seen = reply_cnt;
        n = 0;
        while (reply_cnt == seen && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (reply_cnt == seen) begin
            host_err++;
            $display("no reply to %s within %0d cycles at %0t ns", what, limit, $time);
        end
    endtask

    task automatic press_start();
        xmodem_checker_inst.expect_reply(xmodem_pkg::NAK);
        start_btn = 1'b0;
        repeat (4) @(negedge clk);
        start_btn = 1'b1;
    endtask

    task automatic send_block(input logic [7:0] kind, input logic [7:0] num,
                              input logic [7:0] seed);
        logic [7:0] data;
        logic [7:0] sum;
        logic [7:0] cmp;
        lfsr = LFSR_SEED ^ {24'h0, seed};
        sum = 8'h00;
        cmp = (kind == "N") ? (~num ^ 8'h01) : ~num;
        if (kind == "G" || kind == "R") begin
            xmodem_checker_inst.expect_block(num);
            xmodem_checker_inst.expect_reply(xmodem_pkg::ACK);
        end else begin
            xmodem_checker_inst.expect_reply(xmodem_pkg::NAK);
        end
        send_byte(xmodem_pkg::SOH);
        send_byte(num);
        send_byte(cmp);
        for (int i = 0; i < xmodem_pkg::BLOCK_BYTES; i++) begin
            next_payload_byte(data);
            xmodem_checker_inst.expect_payload(data);
            sum = sum + data;
            send_byte(data);
        end
        if (kind == "C") begin
            sum = sum + 8'h01;
        end
        send_byte(sum);
        wait_reply(REPLY_WAIT, "block");
    endtask

    // start NAK, then timed NAKs until the retries run out
    task automatic run_timeouts();
        press_start();
        wait_reply(REPLY_WAIT, "start press");
        for (int i = 0; i < xmodem_pkg::MAX_RETRY; i++) begin
            xmodem_checker_inst.expect_reply(xmodem_pkg::NAK);
            wait_reply(TIMEOUT_WAIT, "idle line");
        end
        repeat (2 * xmodem_pkg::NAK_TIMEOUT_CYC) @(negedge clk);
    endtask

    task automatic run_action(input logic [7:0] kind, input logic [7:0] num,
                              input logic [7:0] seed);
        case (kind)
            "G", "C", "N", "R": begin
                send_block(kind, num, seed);
            end
            "E": begin
                xmodem_checker_inst.expect_reply(xmodem_pkg::ACK);
                xmodem_checker_inst.expect_done();
                send_byte(xmodem_pkg::EOT);
                wait_reply(REPLY_WAIT, "eot");
            end
            "T": begin
                run_timeouts();
            end
            default: begin
                host_err++;
                $display("unknown action %c in input file", kind);
            end
        endcase
    endtask

    initial begin
        int fd;
        int n;
        int actions;
        string line;
        logic [7:0] kind;
        logic [7:0] num;
        logic [7:0] seed;
        rst = 1'b1;
        start_btn = 1'b1;
        rx_pin = 1'b1;
        actions = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) @(negedge clk);
        press_start();
        wait_reply(REPLY_WAIT, "first start press");
        fd = $fopen(INPUT_FILE, "r");
        if (fd == 0) begin
            host_err++;
            $display("could not open %s", INPUT_FILE);
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", kind, num, seed);
                    if (n != 3) begin
                        host_err++;
                        $display("malformed line in input file: %s", line);
                    end else begin
                        actions++;
                        run_action(kind, num, seed);
                    end
                end
            end
            $fclose(fd);
        end
        if (actions == 0) begin
            host_err++;
            $display("input file held no actions");
        end
        repeat (4 * CPB) @(negedge clk);
        xmodem_checker_inst.check_drained();
        $display("errors: %0d in checks, %0d in host", err_cnt, host_err);
        if (err_cnt == 0 && host_err == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* tb/xmodem_input.txt */
# kind block seed, block and seed in hex
# G good, C bad checksum, N bad complement, R repeat, E eot, T timeouts
G 01 00
G 02 11
C 03 22
G 03 22
N 04 33
G 04 33
R 04 33
G 05 44
C 06 55
N 06 55
G 06 55
R 06 55
E 00 00
T 00 00

/* flist.f */
hdl/xmodem_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/xmodem_block_checker.sv
hdl/xmodem_protocol_ctrl.sv
hdl/xmodem_rx_top.sv
tb/xmodem_checker.sv
tb/tb_xmodem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_xmodem \
    -f flist.f \
    -o tb_xmodem_sim

./obj_dir/tb_xmodem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
exit 1
